// File: logic/spk_pkg.sv
// Shared definitions for the spiking QKV projection unit
// Widths, sizes, default weight bases and FSM encodings
package spk_pkg;

    // Geometry
    localparam int DIM        = 16;   // Weight vector length, spikes per time step
    localparam int TIME_STEPS = 4;

    // Datapath widths
    localparam int WEIGHT_W = 8;
    localparam int PSUM_W   = 20;    // Partial sum and membrane
    localparam int ADDR_W   = 12;
    localparam int LEN_W    = 8;

    // Default weight locations in external memory
    localparam logic [ADDR_W-1:0] Q_BASE = 12'd0;
    localparam logic [ADDR_W-1:0] K_BASE = 12'd64;
    localparam logic [ADDR_W-1:0] V_BASE = 12'd128;

    typedef enum logic [1:0] {
        IDLE,
        REQ,     // Burst requested, waiting for the first beat
        STREAM
    } loader_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

// File: logic/burst_rd_if.sv
// Burst read channel between a weight loader and the memory arbiter
// Requester holds req/addr/len until finish; server returns len beats
`timescale 1ns/1ps

interface burst_rd_if;
    import spk_pkg::*;

    logic                req;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
    logic                valid;
    logic [WEIGHT_W-1:0] data;
    logic                finish;   // One cycle after the last beat

    modport requester (
        output req, addr, len,
        input  valid, data, finish
    );

    modport server (
        input  req, addr, len,
        output valid, data, finish
    );

endinterface

// File: logic/rr_burst_arb.sv
// Round-robin burst read arbiter
// Three requesters share one memory read port, one whole burst at a time
`timescale 1ns/1ps

module rr_burst_arb (
    input  logic                         s_clk,
    input  logic                         i_rst_n,
    burst_rd_if.server                   q_port,
    burst_rd_if.server                   k_port,
    burst_rd_if.server                   v_port,
    output logic                         o_mem_rd_req,
    output logic [spk_pkg::ADDR_W-1:0]   o_mem_rd_addr,
    output logic [spk_pkg::LEN_W-1:0]    o_mem_rd_len,
    input  logic                         i_mem_rd_valid,
    input  logic [spk_pkg::WEIGHT_W-1:0] i_mem_rd_data,
    input  logic                         i_mem_rd_finish
);
    import spk_pkg::*;

    arb_state_t        state;
    logic [1:0]        grant_r;   // Owner of the burst in flight
    logic [1:0]        ptr;       // First in line for the next grant
    logic [1:0]        pick;
    logic [1:0]        sel;
    logic              busy;
    logic [2:0]        req_vec;
    logic [ADDR_W-1:0] addr_arr [3];
    logic [LEN_W-1:0]  len_arr [3];

    assign req_vec     = {v_port.req, k_port.req, q_port.req};
    assign addr_arr[0] = q_port.addr;
    assign addr_arr[1] = k_port.addr;
    assign addr_arr[2] = v_port.addr;
    assign len_arr[0]  = q_port.len;
    assign len_arr[1]  = k_port.len;
    assign len_arr[2]  = v_port.len;

    // Scan from the farthest slot back to ptr so the nearest requester wins
    always_comb begin
        logic [2:0] cand;
        pick = ptr;
        for (int i = 2; i >= 0; i--) begin
            cand = {1'b0, ptr} + 3'(i);
            if (cand >= 3'd3)
                cand = cand - 3'd3;
            if (req_vec[cand[1:0]])
                pick = cand[1:0];
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ARB_IDLE;
            grant_r <= 2'd0;
            ptr     <= 2'd0;   // Q first after reset
        end else begin
            case (state)
                ARB_IDLE: if (|req_vec) begin
                    grant_r <= pick;
                    ptr     <= (pick == 2'd2) ? 2'd0 : pick + 2'd1;
                    state   <= ARB_BUSY;
                end
                ARB_BUSY: if (i_mem_rd_finish) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    assign busy = (state == ARB_BUSY);
    assign sel  = busy ? grant_r : pick;   // Grant is visible in the request cycle

    assign o_mem_rd_req  = busy ? req_vec[grant_r] : |req_vec;
    assign o_mem_rd_addr = addr_arr[sel];
    assign o_mem_rd_len  = len_arr[sel];

    // Return path goes to the owner only
    assign q_port.valid  = busy && (grant_r == 2'd0) && i_mem_rd_valid;
    assign k_port.valid  = busy && (grant_r == 2'd1) && i_mem_rd_valid;
    assign v_port.valid  = busy && (grant_r == 2'd2) && i_mem_rd_valid;
    assign q_port.finish = busy && (grant_r == 2'd0) && i_mem_rd_finish;
    assign k_port.finish = busy && (grant_r == 2'd1) && i_mem_rd_finish;
    assign v_port.finish = busy && (grant_r == 2'd2) && i_mem_rd_finish;
    assign q_port.data   = i_mem_rd_data;
    assign k_port.data   = i_mem_rd_data;
    assign v_port.data   = i_mem_rd_data;

endmodule

// File: logic/weight_loader.sv
// Weight loader for one projection channel
// Requests a DIM-beat burst at its base address and streams the beats out
`timescale 1ns/1ps

module weight_loader #(
    parameter logic [spk_pkg::ADDR_W-1:0] WEIGHT_BASE = spk_pkg::Q_BASE
) (
    input  logic                         s_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    burst_rd_if.requester                rd,
    output logic                         o_w_valid,
    output logic [spk_pkg::WEIGHT_W-1:0] o_w_data,
    output logic                         o_w_done
);
    import spk_pkg::*;

    loader_state_t state;
    logic          busy;

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (i_start) state <= REQ;   // Start ignored while busy
                REQ: begin
                    if (rd.finish)
                        state <= IDLE;
                    else if (rd.valid)
                        state <= STREAM;
                end
                STREAM:  if (rd.finish) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE);

    // Request held until finish, dropped the cycle after
    assign rd.req  = busy;
    assign rd.addr = WEIGHT_BASE;
    assign rd.len  = LEN_W'(DIM);

    assign o_w_valid = busy && rd.valid;
    assign o_w_data  = rd.data;
    assign o_w_done  = busy && rd.finish;

endmodule

// File: logic/spike_accumulator.sv
// Spike-gated weight accumulator
// Beat n adds weight n to the sum of every time step whose spike n is set
`timescale 1ns/1ps

module spike_accumulator (
    input  logic                                          s_clk,
    input  logic                                          i_rst_n,
    input  logic [spk_pkg::TIME_STEPS*spk_pkg::DIM-1:0]   i_spikes,   // Bit t*DIM+n
    input  logic                                          i_w_valid,
    input  logic [spk_pkg::WEIGHT_W-1:0]                  i_w_data,
    input  logic                                          i_w_done,
    output logic [spk_pkg::TIME_STEPS*spk_pkg::PSUM_W-1:0] o_psum,
    output logic                                          o_psum_valid
);
    import spk_pkg::*;

    logic [$clog2(DIM)-1:0]   beat_idx;
    logic signed [PSUM_W-1:0] acc [TIME_STEPS];
    logic signed [PSUM_W-1:0] w_ext;

    assign w_ext = {{(PSUM_W-WEIGHT_W){i_w_data[WEIGHT_W-1]}}, i_w_data};

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_idx     <= '0;
            o_psum       <= '0;
            o_psum_valid <= 1'b0;
            for (int t = 0; t < TIME_STEPS; t++)
                acc[t] <= '0;
        end else begin
            o_psum_valid <= i_w_done;
            if (i_w_done) begin
                // Publish and start the next vector clean
                for (int t = 0; t < TIME_STEPS; t++) begin
                    o_psum[t*PSUM_W +: PSUM_W] <= acc[t];
                    acc[t]                     <= '0;
                end
                beat_idx <= '0;
            end else if (i_w_valid) begin
                for (int t = 0; t < TIME_STEPS; t++) begin
                    if (i_spikes[t*DIM + int'(beat_idx)])
                        acc[t] <= acc[t] + w_ext;
                end
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

// File: logic/lif_group.sv
// Leaky integrate-and-fire neuron over the time steps of one input
// Time constant 2, hard reset to zero on a spike
`timescale 1ns/1ps

module lif_group (
    input  logic                                           s_clk,
    input  logic                                           i_rst_n,
    input  logic signed [spk_pkg::PSUM_W-1:0]              i_thrd,
    input  logic [spk_pkg::TIME_STEPS*spk_pkg::PSUM_W-1:0] i_psum,
    input  logic                                           i_psum_valid,
    output logic [spk_pkg::TIME_STEPS-1:0]                 o_spikes,
    output logic                                           o_spikes_valid
);
    import spk_pkg::*;

    logic [TIME_STEPS-1:0] spk_next;

    // Membrane unrolled over all steps, each run starts from rest
    always_comb begin
        logic signed [PSUM_W-1:0] mem;
        logic signed [PSUM_W-1:0] x;
        logic signed [PSUM_W:0]   diff;   // One extra bit so x - mem cannot wrap
        mem = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            x           = i_psum[t*PSUM_W +: PSUM_W];
            diff        = x - mem;
            mem         = PSUM_W'(mem + (diff >>> 1));   // Floor of half the difference
            spk_next[t] = (mem >= i_thrd);
            if (spk_next[t])
                mem = '0;
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_spikes       <= '0;
            o_spikes_valid <= 1'b0;
        end else begin
            o_spikes_valid <= i_psum_valid;
            if (i_psum_valid)
                o_spikes <= spk_next;
        end
    end

endmodule

// File: logic/qkv_encoder_top.sv
// Spiking QKV projection unit
// Three loader/accumulator/LIF channels sharing one burst read port
`timescale 1ns/1ps

module qkv_encoder_top #(
    parameter logic [spk_pkg::ADDR_W-1:0] Q_ADDR = spk_pkg::Q_BASE,
    parameter logic [spk_pkg::ADDR_W-1:0] K_ADDR = spk_pkg::K_BASE,
    parameter logic [spk_pkg::ADDR_W-1:0] V_ADDR = spk_pkg::V_BASE
) (
    input  logic                                           s_clk,
    input  logic                                           i_rst_n,
    input  logic                                           i_start,
    input  logic [spk_pkg::TIME_STEPS*spk_pkg::DIM-1:0]    i_spikes,
    input  logic signed [spk_pkg::PSUM_W-1:0]              i_thrd,
    output logic                                           o_mem_rd_req,
    output logic [spk_pkg::ADDR_W-1:0]                     o_mem_rd_addr,
    output logic [spk_pkg::LEN_W-1:0]                      o_mem_rd_len,
    input  logic                                           i_mem_rd_valid,
    input  logic [spk_pkg::WEIGHT_W-1:0]                   i_mem_rd_data,
    input  logic                                           i_mem_rd_finish,
    output logic [spk_pkg::TIME_STEPS*spk_pkg::PSUM_W-1:0] o_q_psum,
    output logic [spk_pkg::TIME_STEPS-1:0]                 o_q_spikes,
    output logic                                           o_q_valid,
    output logic [spk_pkg::TIME_STEPS*spk_pkg::PSUM_W-1:0] o_k_psum,
    output logic [spk_pkg::TIME_STEPS-1:0]                 o_k_spikes,
    output logic                                           o_k_valid,
    output logic [spk_pkg::TIME_STEPS*spk_pkg::PSUM_W-1:0] o_v_psum,
    output logic [spk_pkg::TIME_STEPS-1:0]                 o_v_spikes,
    output logic                                           o_v_valid
);
    import spk_pkg::*;

    burst_rd_if q_rd ();
    burst_rd_if k_rd ();
    burst_rd_if v_rd ();

    logic                q_w_valid, k_w_valid, v_w_valid;
    logic [WEIGHT_W-1:0] q_w_data, k_w_data, v_w_data;
    logic                q_w_done, k_w_done, v_w_done;
    logic                q_psum_valid, k_psum_valid, v_psum_valid;

    rr_burst_arb u_arb (
        .s_clk, .i_rst_n, .q_port(q_rd), .k_port(k_rd), .v_port(v_rd),
        .o_mem_rd_req, .o_mem_rd_addr, .o_mem_rd_len,
        .i_mem_rd_valid, .i_mem_rd_data, .i_mem_rd_finish
    );

    // Q channel
    weight_loader #(.WEIGHT_BASE(Q_ADDR)) u_q_loader (
        .s_clk, .i_rst_n, .i_start, .rd(q_rd),
        .o_w_valid(q_w_valid), .o_w_data(q_w_data), .o_w_done(q_w_done)
    );
    spike_accumulator u_q_acc (
        .s_clk, .i_rst_n, .i_spikes, .i_w_valid(q_w_valid), .i_w_data(q_w_data),
        .i_w_done(q_w_done), .o_psum(o_q_psum), .o_psum_valid(q_psum_valid)
    );
    lif_group u_q_lif (
        .s_clk, .i_rst_n, .i_thrd, .i_psum(o_q_psum), .i_psum_valid(q_psum_valid),
        .o_spikes(o_q_spikes), .o_spikes_valid(o_q_valid)
    );

    // K channel
    weight_loader #(.WEIGHT_BASE(K_ADDR)) u_k_loader (
        .s_clk, .i_rst_n, .i_start, .rd(k_rd),
        .o_w_valid(k_w_valid), .o_w_data(k_w_data), .o_w_done(k_w_done)
    );
    spike_accumulator u_k_acc (
        .s_clk, .i_rst_n, .i_spikes, .i_w_valid(k_w_valid), .i_w_data(k_w_data),
        .i_w_done(k_w_done), .o_psum(o_k_psum), .o_psum_valid(k_psum_valid)
    );
    lif_group u_k_lif (
        .s_clk, .i_rst_n, .i_thrd, .i_psum(o_k_psum), .i_psum_valid(k_psum_valid),
        .o_spikes(o_k_spikes), .o_spikes_valid(o_k_valid)
    );

    // V channel
    weight_loader #(.WEIGHT_BASE(V_ADDR)) u_v_loader (
        .s_clk, .i_rst_n, .i_start, .rd(v_rd),
        .o_w_valid(v_w_valid), .o_w_data(v_w_data), .o_w_done(v_w_done)
    );
    spike_accumulator u_v_acc (
        .s_clk, .i_rst_n, .i_spikes, .i_w_valid(v_w_valid), .i_w_data(v_w_data),
        .i_w_done(v_w_done), .o_psum(o_v_psum), .o_psum_valid(v_psum_valid)
    );
    lif_group u_v_lif (
        .s_clk, .i_rst_n, .i_thrd, .i_psum(o_v_psum), .i_psum_valid(v_psum_valid),
        .o_spikes(o_v_spikes), .o_spikes_valid(o_v_valid)
    );

endmodule

// File: dv/qkv_encoder_tb.sv
// Testbench for the spiking QKV projection unit
// Plays the burst memory, models the partial sums and LIF spikes, runs directed tests
`timescale 1ns/1ps

module qkv_encoder_tb;
    import spk_pkg::*;

    localparam int MAX_CYCLES = 20000;   // Ten runs of at most ~600 cycles each fit well inside

    logic                         s_clk = 1'b0;
    logic                         i_rst_n, i_start;
    logic [TIME_STEPS*DIM-1:0]    i_spikes;
    logic signed [PSUM_W-1:0]     i_thrd;
    logic                         o_mem_rd_req, i_mem_rd_valid, i_mem_rd_finish;
    logic [ADDR_W-1:0]            o_mem_rd_addr;
    logic [LEN_W-1:0]             o_mem_rd_len;
    logic [WEIGHT_W-1:0]          i_mem_rd_data;
    logic [TIME_STEPS*PSUM_W-1:0] out_psum [3];
    logic [TIME_STEPS-1:0]        out_spk [3];
    logic [2:0]                   out_valid;

    // Memory model and scoreboard state
    logic signed [WEIGHT_W-1:0]   mem_words [256];
    logic [ADDR_W-1:0]            log_addr [$];
    logic [LEN_W-1:0]             log_len [$];
    logic                         mem_busy, mem_cool;
    logic [ADDR_W-1:0]            mem_ptr, mem_base;
    int                           mem_wait, mem_left, max_delay, max_gap;
    int                           cycle, errors;
    int                           fin_cyc [3];
    int                           valid_cnt [3];
    logic [TIME_STEPS*PSUM_W-1:0] got_psum [3];
    logic [TIME_STEPS-1:0]        got_spk [3];
    string                        cur_test;
    string                        chan_names [3] = '{"q", "k", "v"};
    logic [ADDR_W-1:0]            bases [3] = '{Q_BASE, K_BASE, V_BASE};

    qkv_encoder_top dut0 (
        .s_clk, .i_rst_n, .i_start, .i_spikes, .i_thrd,
        .o_mem_rd_req, .o_mem_rd_addr, .o_mem_rd_len,
        .i_mem_rd_valid, .i_mem_rd_data, .i_mem_rd_finish,
        .o_q_psum(out_psum[0]), .o_q_spikes(out_spk[0]), .o_q_valid(out_valid[0]),
        .o_k_psum(out_psum[1]), .o_k_spikes(out_spk[1]), .o_k_valid(out_valid[1]),
        .o_v_psum(out_psum[2]), .o_v_spikes(out_spk[2]), .o_v_valid(out_valid[2])
    );

    always #10 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
        if (cycle == MAX_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d plus the timeout", errors);
            $display("Test failures found");
            $finish;
        end
    end

    // Burst memory with an idle delay, gapped beats and a finish right after the last beat
    always @(negedge s_clk) begin
        i_mem_rd_valid  <= 1'b0;
        i_mem_rd_finish <= 1'b0;
        if (!i_rst_n) begin
            mem_busy <= 1'b0;
            mem_cool <= 1'b0;
        end else if (mem_cool) begin
            mem_cool <= 1'b0;   // One quiet cycle before req is looked at again
        end else if (!mem_busy) begin
            if (o_mem_rd_req) begin
                log_addr.push_back(o_mem_rd_addr);
                log_len.push_back(o_mem_rd_len);
                mem_busy <= 1'b1;
                mem_ptr  <= o_mem_rd_addr;
                mem_base <= o_mem_rd_addr;
                mem_left <= int'(o_mem_rd_len);
                mem_wait <= $urandom_range(max_delay, 1);
            end
        end else if (mem_wait != 0) begin
            mem_wait <= mem_wait - 1;
        end else if (mem_left != 0) begin
            i_mem_rd_valid <= 1'b1;
            i_mem_rd_data  <= mem_words[mem_ptr[7:0]];
            mem_ptr        <= mem_ptr + 1'b1;
            mem_left       <= mem_left - 1;
            mem_wait       <= (mem_left == 1) ? 0 : $urandom_range(max_gap, 0);
        end else begin
            i_mem_rd_finish <= 1'b1;
            mem_busy        <= 1'b0;
            mem_cool        <= 1'b1;
            for (int ch = 0; ch < 3; ch++)
                if (mem_base == bases[ch]) fin_cyc[ch] <= cycle;
        end
    end

    // Output monitor that also checks the valid latency against the burst finish
    always @(negedge s_clk) begin
        for (int ch = 0; ch < 3; ch++) begin
            if (out_valid[ch]) begin
                valid_cnt[ch]++;
                got_psum[ch] = out_psum[ch];
                got_spk[ch]  = out_spk[ch];
                check_value({cur_test, "/", chan_names[ch], "_latency"}, fin_cyc[ch] + 2, cycle);
            end
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic int model_psum(input int base, input int t);
        int sum;
        sum = 0;
        for (int n = 0; n < DIM; n++)
            if (i_spikes[t*DIM + n]) sum += int'(mem_words[base + n]);
        return sum;
    endfunction

    // LIF with tau 2 and a hard return to rest after each spike
    function automatic int model_spikes(input int base, input int thr);
        int v;
        int d;
        int s;
        v = 0;
        s = 0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            d = model_psum(base, t) - v;
            v = v + ((d >= 0) ? d / 2 : -((1 - d) / 2));
            if (v >= thr) begin
                s = s | (1 << t);
                v = 0;
            end
        end
        return s;
    endfunction

    task automatic fill_weights();
        for (int a = 0; a < 256; a++)
            mem_words[a] = WEIGHT_W'($urandom);
    endtask

    task automatic run_and_check(input logic [TIME_STEPS*DIM-1:0] spikes, input int thr);
        for (int ch = 0; ch < 3; ch++)
            valid_cnt[ch] = 0;
        @(negedge s_clk);
        i_spikes <= spikes;
        i_thrd   <= PSUM_W'(thr);
        i_start  <= 1'b1;
        @(negedge s_clk);
        i_start <= 1'b0;
        while (valid_cnt[0] == 0 || valid_cnt[1] == 0 || valid_cnt[2] == 0)
            @(posedge s_clk);
        repeat (4) @(posedge s_clk);
        for (int ch = 0; ch < 3; ch++) begin
            check_value({cur_test, "/", chan_names[ch], "_valid_count"}, 1, valid_cnt[ch]);
            for (int t = 0; t < TIME_STEPS; t++)
                check_value({cur_test, "/", chan_names[ch], "_psum"}, model_psum(bases[ch], t),
                            int'($signed(got_psum[ch][t*PSUM_W +: PSUM_W])));
            check_value({cur_test, "/", chan_names[ch], "_spikes"},
                        model_spikes(bases[ch], thr), int'(got_spk[ch]));
        end
    endtask

    task automatic single_run();
        cur_test = "single_run";
        fill_weights();
        run_and_check({$urandom, $urandom}, 100);
    endtask

    task automatic arb_order();
        cur_test = "arb_order";
        for (int r = 0; r < 2; r++) begin
            log_addr.delete();
            log_len.delete();
            run_and_check({$urandom, $urandom}, 100);
            check_value("arb_order/burst_count", 3, log_addr.size());
            for (int b = 0; b < 3 && b < log_addr.size(); b++) begin
                check_value("arb_order/addr", int'(bases[b]), int'(log_addr[b]));
                check_value("arb_order/len", DIM, int'(log_len[b]));
            end
        end
    endtask

    task automatic threshold_extremes();
        cur_test = "thrd_max";
        run_and_check({$urandom, $urandom}, (1 << (PSUM_W - 1)) - 1);
        check_value("thrd_max/all_spikes", 0, int'({got_spk[2], got_spk[1], got_spk[0]}));
        cur_test = "thrd_min";
        run_and_check({$urandom, $urandom}, -(1 << (PSUM_W - 1)));
        check_value("thrd_min/all_spikes", 'hfff, int'({got_spk[2], got_spk[1], got_spk[0]}));
    endtask

    task automatic memory_gaps();
        max_delay = 20;
        max_gap   = 8;
        cur_test  = "gaps_zero";
        run_and_check('0, 100);
        cur_test = "gaps_ones";
        run_and_check('1, 100);
        cur_test = "gaps_random";
        run_and_check({$urandom, $urandom}, 100);
        max_delay = 4;
        max_gap   = 1;
    endtask

    task automatic reset_mid_burst();
        cur_test = "reset_mid_burst";
        @(negedge s_clk);
        i_start <= 1'b1;
        @(negedge s_clk);
        i_start <= 1'b0;
        while (!i_mem_rd_valid) @(posedge s_clk);
        @(negedge s_clk);
        i_rst_n <= 1'b0;
        repeat (2) @(negedge s_clk);
        check_value("reset_mid_burst/req_in_reset", 0, int'(o_mem_rd_req));
        check_value("reset_mid_burst/valid_in_reset", 0, int'(out_valid));
        i_rst_n <= 1'b1;
        repeat (2) @(negedge s_clk);
        check_value("reset_mid_burst/req_after", 0, int'(o_mem_rd_req));
        check_value("reset_mid_burst/valid_after", 0, int'(out_valid));
        run_and_check({$urandom, $urandom}, 100);
    endtask

    initial begin
        void'($urandom(32'hcc41d0ad));
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_spikes = '0;
        i_thrd = '0;
        i_mem_rd_valid = 1'b0;
        i_mem_rd_data = '0;
        i_mem_rd_finish = 1'b0;
        cycle = 0;
        errors = 0;
        max_delay = 4;
        max_gap = 1;
        mem_wait = 0;
        mem_left = 0;
        fin_cyc = '{0, 0, 0};
        valid_cnt = '{0, 0, 0};
        cur_test = "reset";
        repeat (16) @(negedge s_clk);
        i_rst_n <= 1'b1;
        single_run();
        arb_order();
        threshold_extremes();
        memory_gaps();
        reset_mid_burst();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: build.f
logic/spk_pkg.sv
logic/burst_rd_if.sv
logic/rr_burst_arb.sv
logic/weight_loader.sv
logic/spike_accumulator.sv
logic/lif_group.sv
logic/qkv_encoder_top.sv
dv/qkv_encoder_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the QKV encoder testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module qkv_encoder_tb -f build.f -o qkv_sim \
    || { echo "Build failed"; exit 1; }
out="$(./obj_dir/qkv_sim)"
echo "$out"
echo "$out" | grep -qF "All tests passed!" && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
